//--- common/cart_settings.svh
/*
 Download constants for the cart loader. All offsets are byte addresses on
 the download bus and so still include the 512-byte copier header.
*/

`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ==========================================================
// Download stream
// ==========================================================

// Copier header in front of every cart image
`define CART_COPIER_BYTES 512

// Loader index reserved for cheat code files
`define CART_CODE_INDEX 8'hFF

// ROM size code used when the header gives nothing better
`define CART_DEFAULT_ROM_SIZE 4'hC

// ==========================================================
// Internal header locations per map mode
// ==========================================================

`define CART_LOROM_SIZE_OFS (25'h7FD6 + 25'h200)
`define CART_LOROM_RAM_OFS (25'h7FD8 + 25'h200)

`define CART_HIROM_SIZE_OFS (25'hFFD6 + 25'h200)
`define CART_HIROM_RAM_OFS (25'hFFD8 + 25'h200)

`define CART_EXHIROM_SIZE_OFS (25'h40FFD6 + 25'h200)
`define CART_EXHIROM_RAM_OFS (25'h40FFD8 + 25'h200)

`endif

//--- common/cart_pkg.sv
/*
 Types shared by the cart loader. Map mode codes follow the menu order of
 the core: auto, no header, LoROM, HiROM, ExHiROM.
*/

`default_nettype none

package cart_pkg;

	// ==========================================================
	// Widths
	// ==========================================================

	localparam int DL_ADDR_W = 25;
	localparam int DL_WORD_W = 16;
	localparam int MASK_W = 24;
	localparam int CODE_WORD_W = 32;

	typedef logic [DL_ADDR_W-1:0] dl_addr_t;
	typedef logic [DL_WORD_W-1:0] dl_word_t;
	typedef logic [MASK_W-1:0] mask_t;

	// One field of a cheat record, big endian as delivered by the loader
	typedef logic [CODE_WORD_W-1:0] code_word_t;

	// ==========================================================
	// Enums
	// ==========================================================

	// ROM header handling as picked in the menu
	typedef enum logic [2:0] {
		MAP_AUTO = 3'd0,
		MAP_NO_HEADER = 3'd1,
		MAP_LOROM = 3'd2,
		MAP_HIROM = 3'd3,
		MAP_EXHIROM = 3'd4
	} map_mode_t;

	// What the router slot currently holds
	typedef enum logic [1:0] {
		BEAT_NONE = 2'd0,
		BEAT_CART = 2'd1,
		BEAT_CODE = 2'd2
	} beat_kind_t;

endpackage

`default_nettype wire

//--- loader/download_router.sv
/*
 First stage. Holds one download word and sends it to the ROM port or the
 cheat assembler. beat_addr is raw for cart words and header adjusted for
 cheat words. cart_done fires once per cart download after its last word.
*/

`default_nettype none

`include "cart_settings.svh"

module download_router (
	input wire clk_sys,
	input wire reset,

	input wire dl_valid,
	output logic dl_ready,
	input wire dl_active,
	input wire [7:0] dl_index,
	input cart_pkg::dl_addr_t dl_addr,
	input cart_pkg::dl_word_t dl_data,

	output logic rom_wr_valid,
	input wire rom_wr_ready,
	output cart_pkg::dl_addr_t rom_wr_addr,
	output cart_pkg::dl_word_t rom_wr_data,

	output logic cart_beat,
	output cart_pkg::dl_addr_t beat_addr,
	output cart_pkg::dl_word_t beat_data,
	output logic code_beat_valid,
	input wire code_beat_ready,

	output logic cart_done
);
	import cart_pkg::*;

	beat_kind_t slot_kind;
	beat_kind_t in_kind;
	dl_addr_t slot_addr;
	dl_addr_t adj_addr;
	dl_word_t slot_data;
	logic accept;
	logic slot_leave;
	logic active_q;
	logic cart_seen;
	logic done_wait;

	// ==========================================================
	// Slot control
	// ==========================================================

	assign in_kind = (dl_index == `CART_CODE_INDEX) ? BEAT_CODE : BEAT_CART;

	assign rom_wr_valid = (slot_kind == BEAT_CART);
	assign code_beat_valid = (slot_kind == BEAT_CODE);
	assign cart_beat = rom_wr_valid & rom_wr_ready;
	assign slot_leave = cart_beat | (code_beat_valid & code_beat_ready);

	// Accept when empty or when the held word leaves this cycle
	assign dl_ready = (slot_kind == BEAT_NONE) | slot_leave;
	assign accept = dl_valid & dl_ready;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			slot_kind <= BEAT_NONE;
		end else if (accept) begin
			slot_kind <= in_kind;
		end else if (slot_leave) begin
			slot_kind <= BEAT_NONE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			slot_addr <= dl_addr;
			slot_data <= dl_data;
		end
	end

	// Strip the copier header
	assign adj_addr = slot_addr - dl_addr_t'(`CART_COPIER_BYTES);

	assign rom_wr_addr = adj_addr;
	assign rom_wr_data = slot_data;
	assign beat_addr = (slot_kind == BEAT_CODE) ? adj_addr : slot_addr;
	assign beat_data = slot_data;

	// ==========================================================
	// End of cart download
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			active_q <= 1'b0;
			cart_seen <= 1'b0;
			done_wait <= 1'b0;
			cart_done <= 1'b0;
		end else begin
			active_q <= dl_active;
			cart_done <= 1'b0;
			if (accept && in_kind == BEAT_CART) begin
				cart_seen <= 1'b1;
			end
			if (active_q && !dl_active && cart_seen) begin
				cart_seen <= 1'b0;
				done_wait <= 1'b1;
			end else if (done_wait && slot_kind == BEAT_NONE) begin
				// Last word has reached the ROM port
				done_wait <= 1'b0;
				cart_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- loader/header_parser.sv
/*
 Second stage for cart words. Reads the ROM map info from the copier
 header or from the internal header at the offsets of the selected mode.
 Outputs follow the cart word by one cycle and are final once info_valid.
*/

`default_nettype none

`include "cart_settings.svh"

module header_parser (
	input wire clk_sys,
	input wire reset,

	input cart_pkg::map_mode_t map_mode,
	input wire cart_beat,
	input cart_pkg::dl_addr_t beat_addr,
	input cart_pkg::dl_word_t beat_data,
	input wire cart_done,

	output logic [7:0] rom_type,
	output logic rom_region,
	output cart_pkg::mask_t rom_mask,
	output cart_pkg::mask_t ram_mask,
	output logic info_valid
);
	import cart_pkg::*;

	logic [3:0] rom_size;
	logic [3:0] ram_size;
	dl_addr_t size_ofs;
	dl_addr_t ram_ofs;
	logic ofs_en;

	// ==========================================================
	// Internal header location
	// ==========================================================

	always_comb begin
		ofs_en = 1'b1;
		size_ofs = `CART_LOROM_SIZE_OFS;
		ram_ofs = `CART_LOROM_RAM_OFS;
		case (map_mode)
			MAP_HIROM: begin
				size_ofs = `CART_HIROM_SIZE_OFS;
				ram_ofs = `CART_HIROM_RAM_OFS;
			end
			MAP_EXHIROM: begin
				size_ofs = `CART_EXHIROM_SIZE_OFS;
				ram_ofs = `CART_EXHIROM_RAM_OFS;
			end
			MAP_LOROM: ;
			// Auto and no-header take sizes from word 0 only
			default: ofs_en = 1'b0;
		endcase
	end

	// ==========================================================
	// Header capture
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= `CART_DEFAULT_ROM_SIZE;
			ram_size <= 4'h0;
			rom_type <= 8'h00;
			rom_region <= 1'b0;
			info_valid <= 1'b0;
		end else begin
			if (cart_beat) begin
				if (beat_addr == '0) begin
					rom_size <= `CART_DEFAULT_ROM_SIZE;
					ram_size <= 4'h0;
					info_valid <= 1'b0;
					if (map_mode == MAP_AUTO && beat_data[7:0] != 8'h00) begin
						{ram_size, rom_size} <= beat_data[7:0];
					end
					case (map_mode)
						MAP_NO_HEADER, MAP_LOROM: rom_type <= 8'd0;
						MAP_HIROM: rom_type <= 8'd1;
						MAP_EXHIROM: rom_type <= 8'd2;
						default: rom_type <= beat_data[15:8];
					endcase
				end

				if (beat_addr == dl_addr_t'(2)) begin
					rom_region <= beat_data[8];
				end

				if (ofs_en && beat_addr == size_ofs) begin
					rom_size <= beat_data[11:8];
				end
				if (ofs_en && beat_addr == ram_ofs) begin
					ram_size <= beat_data[3:0];
				end
			end

			if (cart_done) begin
				info_valid <= 1'b1;
			end
		end
	end

	// Size code n means 1 KiB << n
	assign rom_mask = (mask_t'(1024) << rom_size) - mask_t'(1);
	assign ram_mask = (ram_size != 4'h0) ? (mask_t'(1024) << ram_size) - mask_t'(1) : '0;

endmodule

`default_nettype wire

//--- loader/cheat_assembler.sv
/*
 Second stage for cheat words. Eight 16-bit words, low half first, make one
 record. Words on odd byte addresses are taken and dropped.
 A finished record is held until code_ready.
*/

`default_nettype none

module cheat_assembler (
	input wire clk_sys,
	input wire reset,

	input wire code_beat_valid,
	output logic code_beat_ready,
	input cart_pkg::dl_addr_t beat_addr,
	input cart_pkg::dl_word_t beat_data,

	output logic code_valid,
	input wire code_ready,
	output cart_pkg::code_word_t code_flags,
	output cart_pkg::code_word_t code_addr,
	output cart_pkg::code_word_t code_compare,
	output cart_pkg::code_word_t code_replace
);
	import cart_pkg::*;

	dl_word_t flags_lo;
	dl_word_t flags_hi;
	dl_word_t addr_lo;
	dl_word_t addr_hi;
	dl_word_t compare_lo;
	dl_word_t compare_hi;
	dl_word_t replace_lo;
	logic [3:0] slot;
	logic take;
	logic last;

	assign slot = beat_addr[3:0];
	assign last = (slot == 4'd14);

	// Only the closing word needs the output register, so the next
	// record can build up while the previous one waits
	assign code_beat_ready = !code_valid || code_ready || !last;
	assign take = code_beat_valid & code_beat_ready;

	// ==========================================================
	// Record build-up
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (slot)
				4'd0: flags_lo <= beat_data;
				4'd2: flags_hi <= beat_data;
				4'd4: addr_lo <= beat_data;
				4'd6: addr_hi <= beat_data;
				4'd8: compare_lo <= beat_data;
				4'd10: compare_hi <= beat_data;
				4'd12: replace_lo <= beat_data;
				4'd14: begin
					code_flags <= {flags_hi, flags_lo};
					code_addr <= {addr_hi, addr_lo};
					code_compare <= {compare_hi, compare_lo};
					code_replace <= {beat_data, replace_lo};
				end
				default: ;
			endcase
		end
	end

	// Output handshake
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code_valid <= 1'b0;
		end else begin
			if (code_valid && code_ready) begin
				code_valid <= 1'b0;
			end
			if (take && last) begin
				code_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cart_loader_top.sv
/*
 Cart download front end. Cart words go to the ROM write port and the
 header parser; cheat words become 128-bit code records.
*/

`default_nettype none

module cart_loader_top (
	input wire clk_sys,
	input wire reset,

	input wire dl_valid,
	output logic dl_ready,
	input wire dl_active,
	input wire [7:0] dl_index,
	input cart_pkg::dl_addr_t dl_addr,
	input cart_pkg::dl_word_t dl_data,

	input cart_pkg::map_mode_t map_mode,

	output logic rom_wr_valid,
	input wire rom_wr_ready,
	output cart_pkg::dl_addr_t rom_wr_addr,
	output cart_pkg::dl_word_t rom_wr_data,

	output logic code_valid,
	input wire code_ready,
	output cart_pkg::code_word_t code_flags,
	output cart_pkg::code_word_t code_addr,
	output cart_pkg::code_word_t code_compare,
	output cart_pkg::code_word_t code_replace,

	output logic [7:0] rom_type,
	output logic rom_region,
	output cart_pkg::mask_t rom_mask,
	output cart_pkg::mask_t ram_mask,
	output logic info_valid
);
	import cart_pkg::*;

	logic cart_beat;
	logic cart_done;
	logic code_beat_valid;
	logic code_beat_ready;
	dl_addr_t beat_addr;
	dl_word_t beat_data;

	download_router u_router (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl_valid(dl_valid),
		.dl_ready(dl_ready),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.rom_wr_valid(rom_wr_valid),
		.rom_wr_ready(rom_wr_ready),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.cart_beat(cart_beat),
		.beat_addr(beat_addr),
		.beat_data(beat_data),
		.code_beat_valid(code_beat_valid),
		.code_beat_ready(code_beat_ready),
		.cart_done(cart_done)
	);

	header_parser u_parser (
		.clk_sys(clk_sys),
		.reset(reset),
		.map_mode(map_mode),
		.cart_beat(cart_beat),
		.beat_addr(beat_addr),
		.beat_data(beat_data),
		.cart_done(cart_done),
		.rom_type(rom_type),
		.rom_region(rom_region),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask),
		.info_valid(info_valid)
	);

	cheat_assembler u_cheat (
		.clk_sys(clk_sys),
		.reset(reset),
		.code_beat_valid(code_beat_valid),
		.code_beat_ready(code_beat_ready),
		.beat_addr(beat_addr),
		.beat_data(beat_data),
		.code_valid(code_valid),
		.code_ready(code_ready),
		.code_flags(code_flags),
		.code_addr(code_addr),
		.code_compare(code_compare),
		.code_replace(code_replace)
	);

endmodule

`default_nettype wire

//--- verif/tb_cart_loader.sv
/*
 Directed testbench for cart_loader_top. Ready stalls and payload words
 come from one LFSR with a fixed seed, so every run sees the same stimulus.
 Each wait gives up after WAIT_LIMIT cycles and ends the run.
*/

`default_nettype none

`include "cart_settings.svh"

module tb_cart_loader;
	timeunit 1ns;
	timeprecision 100ps;

	import cart_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic clk_sys;
	logic reset;
	logic dl_valid;
	logic dl_ready;
	logic dl_active;
	logic [7:0] dl_index;
	dl_addr_t dl_addr;
	dl_word_t dl_data;
	map_mode_t map_mode;
	logic rom_wr_valid;
	logic rom_wr_ready;
	dl_addr_t rom_wr_addr;
	dl_word_t rom_wr_data;
	logic code_valid;
	logic code_ready;
	code_word_t code_flags;
	code_word_t code_addr;
	code_word_t code_compare;
	code_word_t code_replace;
	logic [7:0] rom_type;
	logic rom_region;
	mask_t rom_mask;
	mask_t ram_mask;
	logic info_valid;

	logic [31:0] lfsr_state;
	logic stall_en;
	int err_count;
	int check_count;
	int test_count;
	int start_errs;

	// Words to send, and what came out of the two output ports
	dl_addr_t tx_addr_q[$];
	dl_word_t tx_data_q[$];
	dl_addr_t rom_addr_q[$];
	dl_word_t rom_data_q[$];
	code_word_t rec_q[$];
	string code_field[4] = '{"code_flags", "code_addr", "code_compare", "code_replace"};

	cart_loader_top u_dut (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl_valid(dl_valid),
		.dl_ready(dl_ready),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.map_mode(map_mode),
		.rom_wr_valid(rom_wr_valid),
		.rom_wr_ready(rom_wr_ready),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.code_valid(code_valid),
		.code_ready(code_ready),
		.code_flags(code_flags),
		.code_addr(code_addr),
		.code_compare(code_compare),
		.code_replace(code_replace),
		.rom_type(rom_type),
		.rom_region(rom_region),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask),
		.info_valid(info_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Inputs change 1 ns after the rising edge, so the falling edge sees
	// exactly what the next rising edge will see
	always @(negedge clk_sys) begin
		if (rom_wr_valid && rom_wr_ready) begin
			rom_addr_q.push_back(rom_wr_addr);
			rom_data_q.push_back(rom_wr_data);
		end
		if (code_valid && code_ready) begin
			rec_q.push_back(code_flags);
			rec_q.push_back(code_addr);
			rec_q.push_back(code_compare);
			rec_q.push_back(code_replace);
		end
	end

	// ==========================================================
	// Random source and reference model
	// ==========================================================

	// Galois form, taps for x^32 + x^31 + x^29 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hD000_0001;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic dl_word_t draw_word();
		logic [31:0] b;
		b = draw_bits(16);
		return b[15:0];
	endfunction

	function automatic logic draw_bit();
		logic [31:0] b;
		b = draw_bits(1);
		return b[0];
	endfunction

	// Size code n covers 1 KiB << n, so the mask is 10 + n low ones
	function automatic mask_t expected_mask(input logic [3:0] size, input logic none_when_zero);
		mask_t m;
		m = '0;
		if (!(none_when_zero && size == 4'h0)) begin
			for (int b = 0; b < MASK_W; b++) begin
				m[b] = (b < 10 + int'(size));
			end
		end
		return m;
	endfunction

	// ==========================================================
	// Driving and waiting
	// ==========================================================

	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		err_count++;
		$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
	endtask

	task automatic next_cycle();
		logic [31:0] pick;
		@(posedge clk_sys);
		#1;
		if (stall_en) begin
			pick = draw_bits(2);
			rom_wr_ready = pick[0];
			code_ready = pick[1];
		end else begin
			rom_wr_ready = 1'b1;
			code_ready = 1'b1;
		end
	endtask

	task automatic send_word(input logic [7:0] index, input dl_addr_t addr, input dl_word_t data);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		dl_valid = 1'b1;
		dl_index = index;
		dl_addr = addr;
		dl_data = data;
		while (!taken && waited < WAIT_LIMIT) begin
			@(negedge clk_sys);
			taken = dl_ready;
			next_cycle();
			waited++;
		end
		dl_valid = 1'b0;
		if (!taken) begin
			abort_run("download word was never accepted");
		end
	endtask

	task automatic add_word(input dl_addr_t addr, input dl_word_t data);
		tx_addr_q.push_back(addr);
		tx_data_q.push_back(data);
	endtask

	task automatic run_download(input logic [7:0] index);
		dl_active = 1'b1;
		next_cycle();
		for (int i = 0; i < tx_addr_q.size(); i++) begin
			send_word(index, tx_addr_q[i], tx_data_q[i]);
		end
		next_cycle();
	endtask

	task automatic end_download();
		dl_active = 1'b0;
		next_cycle();
	endtask

	task automatic wait_cart_info(input int words);
		int waited;
		waited = 0;
		while (rom_addr_q.size() < words && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (rom_addr_q.size() < words) begin
			abort_run("cart words missing on the ROM write port");
		end
		waited = 0;
		while (!info_valid && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!info_valid) begin
			abort_run("info_valid did not rise after the download ended");
		end
	endtask

	// Header info must stay invalid until dl_active falls
	task automatic load_cart(input map_mode_t mode, input logic [7:0] index);
		map_mode = mode;
		rom_addr_q.delete();
		rom_data_q.delete();
		run_download(index);
		check_count++;
		if (info_valid !== 1'b0) report_mismatch("info_valid", 32'(info_valid), 32'h0);
		end_download();
		wait_cart_info(tx_addr_q.size());
	endtask

	task automatic check_header(input logic [7:0] exp_type, input logic exp_region,
			input mask_t exp_rom, input mask_t exp_ram);
		check_count += 4;
		if (rom_type !== exp_type) report_mismatch("rom_type", 32'(rom_type), 32'(exp_type));
		if (rom_region !== exp_region) begin
			report_mismatch("rom_region", 32'(rom_region), 32'(exp_region));
		end
		if (rom_mask !== exp_rom) report_mismatch("rom_mask", 32'(rom_mask), 32'(exp_rom));
		if (ram_mask !== exp_ram) report_mismatch("ram_mask", 32'(ram_mask), 32'(exp_ram));
	endtask

	// One image: word 0, word 2 with the region bit, a size word, a RAM word
	task automatic header_case(input map_mode_t mode, input dl_word_t word0, input logic region,
			input dl_addr_t size_addr, input logic [3:0] size_code,
			input dl_addr_t ram_addr, input logic [3:0] ram_code,
			input logic [7:0] exp_type, input logic [3:0] exp_rom, input logic [3:0] exp_ram);
		logic [31:0] r;
		r = draw_bits(32);
		tx_addr_q.delete();
		tx_data_q.delete();
		add_word(dl_addr_t'(0), word0);
		add_word(dl_addr_t'(2), {r[7:1], region, r[15:8]});
		add_word(size_addr, {r[19:16], size_code, r[27:20]});
		add_word(ram_addr, {r[31:20], ram_code});
		load_cart(mode, 8'h00);
		check_header(exp_type, region, expected_mask(exp_rom, 1'b0), expected_mask(exp_ram, 1'b1));
	endtask

	task automatic open_test();
		start_errs = err_count;
		tx_addr_q.delete();
		tx_data_q.delete();
		rom_addr_q.delete();
		rom_data_q.delete();
		rec_q.delete();
	endtask

	task automatic close_test(input string name);
		test_count++;
		$display("%s: %0d error(s)", name, err_count - start_errs);
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	task automatic reset_state();
		open_test();
		check_count += 6;
		if (dl_ready !== 1'b1) report_mismatch("dl_ready", 32'(dl_ready), 32'h1);
		if (rom_wr_valid !== 1'b0) report_mismatch("rom_wr_valid", 32'(rom_wr_valid), 32'h0);
		if (code_valid !== 1'b0) report_mismatch("code_valid", 32'(code_valid), 32'h0);
		if (info_valid !== 1'b0) report_mismatch("info_valid", 32'(info_valid), 32'h0);
		if (u_dut.code_beat_valid !== 1'b0) begin
			report_mismatch("code_beat_valid", 32'(u_dut.code_beat_valid), 32'h0);
		end
		if (u_dut.cart_done !== 1'b0) report_mismatch("cart_done", 32'(u_dut.cart_done), 32'h0);
		close_test("reset state");
	endtask

	// Sizes come from word 0 only, the LoROM offsets are ignored here
	task automatic auto_header();
		open_test();
		header_case(MAP_AUTO, 16'h0A35, 1'b1, `CART_LOROM_SIZE_OFS, 4'h1,
			`CART_LOROM_RAM_OFS, 4'h7, 8'h0A, 4'h5, 4'h3);
		close_test("auto header");
	endtask

	task automatic lorom_sizes();
		open_test();
		header_case(MAP_LOROM, draw_word(), draw_bit(), `CART_LOROM_SIZE_OFS, 4'h9,
			`CART_LOROM_RAM_OFS, 4'h2, 8'h00, 4'h9, 4'h2);
		header_case(MAP_LOROM, draw_word(), draw_bit(), `CART_LOROM_SIZE_OFS, 4'h7,
			`CART_LOROM_RAM_OFS, 4'h0, 8'h00, 4'h7, 4'h0);
		close_test("lorom sizes");
	endtask

	task automatic hirom_and_exhirom();
		open_test();
		header_case(MAP_HIROM, draw_word(), draw_bit(), `CART_LOROM_SIZE_OFS, 4'h3,
			`CART_LOROM_RAM_OFS, 4'h5, 8'h01, `CART_DEFAULT_ROM_SIZE, 4'h0);
		header_case(MAP_HIROM, draw_word(), draw_bit(), `CART_HIROM_SIZE_OFS, 4'hA,
			`CART_HIROM_RAM_OFS, 4'h1, 8'h01, 4'hA, 4'h1);
		header_case(MAP_EXHIROM, draw_word(), draw_bit(), `CART_HIROM_SIZE_OFS, 4'h4,
			`CART_HIROM_RAM_OFS, 4'h2, 8'h02, `CART_DEFAULT_ROM_SIZE, 4'h0);
		header_case(MAP_EXHIROM, draw_word(), draw_bit(), `CART_EXHIROM_SIZE_OFS, 4'hB,
			`CART_EXHIROM_RAM_OFS, 4'h3, 8'h02, 4'hB, 4'h3);
		close_test("hirom and exhirom");
	endtask

	task automatic rom_port_stalls();
		dl_addr_t addr;
		dl_addr_t exp_addr;
		open_test();
		stall_en = 1'b1;
		addr = '0;
		for (int i = 0; i < 24; i++) begin
			add_word(addr, draw_word());
			addr = addr + dl_addr_t'(2);
		end
		load_cart(MAP_NO_HEADER, 8'h05);
		stall_en = 1'b0;
		check_count++;
		if (rom_addr_q.size() != tx_addr_q.size()) begin
			report_mismatch("rom write count", 32'(rom_addr_q.size()), 32'(tx_addr_q.size()));
		end else begin
			for (int i = 0; i < tx_addr_q.size(); i++) begin
				exp_addr = tx_addr_q[i] - dl_addr_t'(`CART_COPIER_BYTES);
				check_count += 2;
				if (rom_addr_q[i] !== exp_addr) begin
					report_mismatch("rom_wr_addr", 32'(rom_addr_q[i]), 32'(exp_addr));
				end
				if (rom_data_q[i] !== tx_data_q[i]) begin
					report_mismatch("rom_wr_data", 32'(rom_data_q[i]), 32'(tx_data_q[i]));
				end
			end
		end
		close_test("rom port stalls");
	endtask

	// Word j of a record lands at nibble 2j, low half before high half
	task automatic cheat_records();
		dl_addr_t base;
		code_word_t exp_field;
		int waited;
		open_test();
		stall_en = 1'b1;
		base = dl_addr_t'(`CART_COPIER_BYTES);
		for (int i = 0; i < 16; i++) begin
			add_word(base + dl_addr_t'(2 * i), draw_word());
		end
		run_download(`CART_CODE_INDEX);
		end_download();
		waited = 0;
		while (rec_q.size() < 8 && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (rec_q.size() < 8) begin
			abort_run("cheat records missing on the code port");
		end
		// Quiet period to catch a record offered twice
		repeat (8) next_cycle();
		stall_en = 1'b0;
		check_count++;
		if (rec_q.size() != 8) begin
			report_mismatch("code record fields", 32'(rec_q.size()), 32'h8);
		end else begin
			for (int k = 0; k < 2; k++) begin
				for (int f = 0; f < 4; f++) begin
					exp_field = {tx_data_q[k * 8 + f * 2 + 1], tx_data_q[k * 8 + f * 2]};
					check_count++;
					if (rec_q[k * 4 + f] !== exp_field) begin
						report_mismatch(code_field[f], rec_q[k * 4 + f], exp_field);
					end
				end
			end
		end
		close_test("cheat records");
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		lfsr_state = 32'h9042_418b;
		reset = 1'b0;
		dl_valid = 1'b0;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_addr = '0;
		dl_data = '0;
		map_mode = MAP_AUTO;
		rom_wr_ready = 1'b1;
		code_ready = 1'b1;
		stall_en = 1'b0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		start_errs = 0;

		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b1;

		reset_state();
		auto_header();
		lorom_sizes();
		hirom_and_exhirom();
		rom_port_stalls();
		cheat_records();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/cart_pkg.sv
loader/download_router.sv
loader/header_parser.sv
loader/cheat_assembler.sv
verilog/cart_loader_top.sv
verif/tb_cart_loader.sv

//--- run_sim.sh
#!/bin/sh
# Compile the cart loader testbench with Verilator and run it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing \
	--timescale 1ns/100ps \
	--top-module tb_cart_loader \
	-f flist.f

./obj_dir/Vtb_cart_loader > sim.log 2>&1

cat sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
else
	exit 1
fi
